// ==== riscv_pipe.f ====
src/riscv_pkg.sv
src/riscv_pipe_if.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/riscv_pipe.sv
sim/riscv_pipe_props.sv
sim/riscv_pipe_tb.sv

// ==== Makefile ====
# Verilator build and run for the RV32I pipeline

VERILATOR ?= verilator
TOP       ?= riscv_pipe_tb
FLIST     ?= riscv_pipe.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell cat $(FLIST))
EXE  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FLIST)

run: $(EXE)
	./$(EXE) 2>&1 | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim/riscv_pipe_tests.txt ====
# P <imem word address> <instruction word>
# E <expected rd> <expected writeback value>, in trace order
P 00 00500093
P 01 ffd00113
P 02 002081b3
P 03 40208233
P 04 0020f2b3
P 05 0020e333
P 06 0020c3b3
P 07 00112433
P 08 0020a4b3
P 09 00700013
P 0a 00100533
P 0b 00402423
P 0c 00802583
P 0d 00158633
P 0e 00160693
P 0f 00c68733
E 01 00000005
E 02 fffffffd
E 03 00000002
E 04 00000008
E 05 00000005
E 06 fffffffd
E 07 fffffff8
E 08 00000001
E 09 00000000
E 0a 00000005
E 0b 00000008
E 0c 0000000d
E 0d 0000000e
E 0e 0000001b

// ==== sim/riscv_pipe_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_pipe_tb import riscv_pkg::*; ();

        localparam int                 IMEM_AW    = 6;
        localparam int                 DMEM_AW    = 6;
        localparam int                 CLK_HALF   = 10;
        localparam logic [INSTR_W-1:0] NOP        = 32'h0000_0013;
        localparam string              TESTS_FILE = "sim/riscv_pipe_tests.txt";

        logic                  clk;
        logic                  i_arst_n;
        logic                  i_run;
        logic                  i_imem_we;
        logic [IMEM_AW-1:0]    i_imem_addr;
        logic [INSTR_W-1:0]    i_imem_data;
        logic                  o_wb_valid;
        logic [REG_ADDR_W-1:0] o_wb_rd;
        logic [XLEN-1:0]       o_wb_data;

        // Program image, NOP where the file gives nothing
        logic [INSTR_W-1:0]    image [2**IMEM_AW];
        // Expected trace
        logic [REG_ADDR_W-1:0] exp_rd [$];
        logic [XLEN-1:0]       exp_data [$];
        int                    n_words      = 0;
        int                    n_seen       = 0;
        int                    n_errors     = 0;
        logic                  tests_loaded = 1'b0;

        riscv_pipe #(
                .IMEM_AW(IMEM_AW),
                .DMEM_AW(DMEM_AW)
        ) dut0 (
                .clk         (clk),
                .i_arst_n    (i_arst_n),
                .i_run       (i_run),
                .i_imem_we   (i_imem_we),
                .i_imem_addr (i_imem_addr),
                .i_imem_data (i_imem_data),
                .o_wb_valid  (o_wb_valid),
                .o_wb_rd     (o_wb_rd),
                .o_wb_data   (o_wb_data)
        );

        //////////////////////////////
        // Checks
        //////////////////////////////

        task automatic check_rd(input int idx, input logic [REG_ADDR_W-1:0] got,
                                input logic [REG_ADDR_W-1:0] exp);
                if (got !== exp) begin
                        $display("FAIL o_wb_rd entry %0d: got %h expected %h", idx, got, exp);
                        n_errors++;
                end
        endtask

        task automatic check_data(input int idx, input logic [XLEN-1:0] got,
                                  input logic [XLEN-1:0] exp);
                if (got !== exp) begin
                        $display("FAIL o_wb_data entry %0d: got %h expected %h", idx, got, exp);
                        n_errors++;
                end
        endtask

        //////////////////////////////
        // Stimulus file and loading
        //////////////////////////////

        // P lines fill the image, E lines the trace
        task automatic read_tests();
                int          fd;
                int          n;
                string       line;
                logic [7:0]  tag;
                logic [31:0] field_a;
                logic [31:0] field_b;
                foreach (image[i]) begin
                        image[i] = NOP;
                end
                fd = $fopen(TESTS_FILE, "r");
                if (fd == 0) begin
                        $display("Cannot open the tests file %s", TESTS_FILE);
                        n_errors++;
                        return;
                end
                while (!$feof(fd)) begin
                        line = "";
                        n = $fgets(line, fd);
                        // Blank and comment lines
                        if (n > 0 && line.len() > 2) begin
                                tag = line.getc(0);
                                if (tag == "P" || tag == "E") begin
                                        n = $sscanf(line.substr(1, line.len() - 1), "%h %h",
                                                    field_a, field_b);
                                        if (n != 2) begin
                                                $display("Malformed line in tests file: %s", line);
                                                n_errors++;
                                        end else if (tag == "P") begin
                                                image[field_a[IMEM_AW-1:0]] = field_b;
                                                n_words++;
                                        end else begin
                                                exp_rd.push_back(field_a[REG_ADDR_W-1:0]);
                                                exp_data.push_back(field_b);
                                        end
                                end
                        end
                end
                $fclose(fd);
        endtask

        // Whole memory written, padding included
        task automatic load_program();
                for (int a = 0; a < 2**IMEM_AW; a++) begin
                        @(posedge clk);
                        i_imem_we   <= 1'b1;
                        i_imem_addr <= a[IMEM_AW-1:0];
                        i_imem_data <= image[a[IMEM_AW-1:0]];
                end
                @(posedge clk);
                i_imem_we <= 1'b0;
        endtask

        task automatic finish_run();
                int missing;
                missing = exp_rd.size() - n_seen;
                if (missing > 0) begin
                        $display("%0d expected writebacks never occurred", missing);
                        n_errors += missing;
                end
                $display("Errors: %0d, trace entries seen: %0d of %0d",
                         n_errors, n_seen, exp_rd.size());
                if (n_errors == 0) begin
                        $display("Result: PASSED");
                end else begin
                        $display("Result: FAILED");
                end
                $finish;
        endtask

        //////////////////////////////
        // Clock, reset, sequence
        //////////////////////////////

        initial begin
                clk = 1'b0;
                forever #CLK_HALF clk = ~clk;
        end

        initial begin
                i_arst_n    = 1'b0;
                i_run       = 1'b0;
                i_imem_we   = 1'b0;
                i_imem_addr = '0;
                i_imem_data = '0;
                read_tests();
                tests_loaded = 1'b1;
                repeat (3) @(posedge clk);
                i_arst_n <= 1'b1;
                load_program();
                @(posedge clk);
                i_run <= 1'b1;
                wait (n_seen >= exp_rd.size());
                // Room for any stray writeback
                repeat (8) @(posedge clk);
                finish_run();
        end

        // Trace monitor, sampled away from the active edge
        always @(negedge clk) begin
                if (o_wb_valid === 1'b1) begin
                        if (!i_run) begin
                                $display("Writeback to x%0d before the program was started",
                                         o_wb_rd);
                                n_errors++;
                        end else if (n_seen < exp_rd.size()) begin
                                check_rd(n_seen, o_wb_rd, exp_rd[n_seen]);
                                check_data(n_seen, o_wb_data, exp_data[n_seen]);
                                n_seen++;
                        end else begin
                                $display("Unexpected extra writeback to x%0d", o_wb_rd);
                                n_errors++;
                        end
                end
        end

        // Watchdog, scaled to the program length
        initial begin
                int limit;
                wait (tests_loaded);
                limit = 20 * n_words + 100;
                repeat (limit) @(posedge clk);
                $display("Timeout after %0d cycles, the trace did not complete", limit);
                n_errors++;
                finish_run();
        end

endmodule

`default_nettype wire

// ==== sim/riscv_pipe_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_pipe_props import riscv_pkg::*; (
        input wire logic                  clk,
        input wire logic                  i_arst_n,
        input wire logic                  i_run,
        input wire logic                  i_wb_valid,
        input wire logic [REG_ADDR_W-1:0] i_wb_rd,
        input wire logic                  i_load_stall,
        input wire logic                  i_id_ex_reg_write,
        input wire logic                  i_id_ex_mem_read,
        input wire logic                  i_id_ex_mem_write
);

        //////////////////////////////
        // Pipeline control
        //////////////////////////////

        // Memory stage filters x0
        wb_rd_nonzero: assert property (@(posedge clk) disable iff (!i_arst_n)
                i_wb_valid |-> (i_wb_rd != '0))
                else $error("Writeback to x0 appeared on the trace");

        // Stalled slot enters ID/EX as a bubble
        stall_leaves_bubble: assert property (@(posedge clk) disable iff (!i_arst_n)
                i_load_stall |=>
                        (!i_id_ex_reg_write && !i_id_ex_mem_read && !i_id_ex_mem_write))
                else $error("Load stall did not leave a bubble in ID/EX");

        // Idle pipeline carries only NOPs
        no_wb_when_idle: assert property (@(posedge clk) disable iff (!i_arst_n)
                !i_run |-> !i_wb_valid)
                else $error("Writeback while the core is not running");

endmodule

bind riscv_pipe riscv_pipe_props u_props (
        .clk               (clk),
        .i_arst_n          (i_arst_n),
        .i_run             (i_run),
        .i_wb_valid        (o_wb_valid),
        .i_wb_rd           (o_wb_rd),
        .i_load_stall      (load_stall),
        .i_id_ex_reg_write (id_ex.reg_write),
        .i_id_ex_mem_read  (id_ex.mem_read),
        .i_id_ex_mem_write (id_ex.mem_write)
);

`default_nettype wire

// ==== src/riscv_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscv_pipe import riscv_pkg::*; #(
        parameter int IMEM_AW = 6,
        parameter int DMEM_AW = 6
) (
        input  wire logic                  clk,
        input  wire logic                  i_arst_n,
        input  wire logic                  i_run,
        input  wire logic                  i_imem_we,
        input  wire logic [IMEM_AW-1:0]    i_imem_addr,
        input  wire logic [INSTR_W-1:0]    i_imem_data,
        output logic                       o_wb_valid,
        output logic      [REG_ADDR_W-1:0] o_wb_rd,
        output logic      [XLEN-1:0]       o_wb_data
);

        logic [INSTR_W-1:0]    if_id_instr;
        logic                  load_stall;
        // Writeback bus, shared by regfile and forwarding
        logic                  wb_write;
        logic [REG_ADDR_W-1:0] wb_rd;
        logic [XLEN-1:0]       wb_data;

        id_ex_if  id_ex ();
        ex_mem_if ex_mem ();

        fetch_stage #(
                .IMEM_AW(IMEM_AW)
        ) u_fetch (
                .clk          (clk),
                .i_arst_n     (i_arst_n),
                .i_run        (i_run),
                .i_load_stall (load_stall),
                .i_imem_we    (i_imem_we),
                .i_imem_addr  (i_imem_addr),
                .i_imem_data  (i_imem_data),
                .o_instr      (if_id_instr)
        );

        decode_stage u_decode (
                .clk          (clk),
                .i_arst_n     (i_arst_n),
                .i_instr      (if_id_instr),
                .i_wb_write   (wb_write),
                .i_wb_rd      (wb_rd),
                .i_wb_data    (wb_data),
                .o_load_stall (load_stall),
                .id_ex        (id_ex.src)
        );

        execute_stage u_execute (
                .clk          (clk),
                .i_arst_n     (i_arst_n),
                .id_ex        (id_ex.dst),
                .i_wb_write   (wb_write),
                .i_wb_rd      (wb_rd),
                .i_wb_data    (wb_data),
                .ex_mem       (ex_mem.src)
        );

        memory_stage #(
                .DMEM_AW(DMEM_AW)
        ) u_memory (
                .clk          (clk),
                .i_arst_n     (i_arst_n),
                .ex_mem       (ex_mem.dst),
                .o_wb_write   (wb_write),
                .o_wb_rd      (wb_rd),
                .o_wb_data    (wb_data)
        );

        // Writeback trace
        assign o_wb_valid = wb_write;
        assign o_wb_rd    = wb_rd;
        assign o_wb_data  = wb_data;

endmodule

`default_nettype wire

// ==== src/memory_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_stage import riscv_pkg::*; #(
        parameter int DMEM_AW = 6
) (
        input  wire logic             clk,
        input  wire logic             i_arst_n,
        ex_mem_if.dst                 ex_mem,
        output logic                  o_wb_write,
        output logic [REG_ADDR_W-1:0] o_wb_rd,
        output logic [XLEN-1:0]       o_wb_data
);

        logic [XLEN-1:0]    dmem [2**DMEM_AW];
        logic [DMEM_AW-1:0] word_idx;
        logic [XLEN-1:0]    load_data;
        logic [XLEN-1:0]    wb_data;

        //////////////////////////////
        // Data memory
        //////////////////////////////

        // Word accesses only
        assign word_idx = ex_mem.alu_result[DMEM_AW+1:2];

        always_ff @(posedge clk) begin
                if (ex_mem.mem_write) begin
                        dmem[word_idx] <= ex_mem.store_data;
                end
        end

        assign load_data = dmem[word_idx];
        assign wb_data   = ex_mem.mem_read ? load_data : ex_mem.alu_result;

        //////////////////////////////
        // MEM/WB
        //////////////////////////////

        // Writes to x0 are dropped here
        always_ff @(posedge clk or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        o_wb_write <= 1'b0;
                end else begin
                        o_wb_write <= ex_mem.reg_write && (ex_mem.rd != '0);
                end
        end

        always_ff @(posedge clk) begin
                o_wb_rd   <= ex_mem.rd;
                o_wb_data <= wb_data;
        end

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage import riscv_pkg::*; (
        input  wire logic                  clk,
        input  wire logic                  i_arst_n,
        id_ex_if.dst                       id_ex,
        input  wire logic                  i_wb_write,
        input  wire logic [REG_ADDR_W-1:0] i_wb_rd,
        input  wire logic [XLEN-1:0]       i_wb_data,
        ex_mem_if.src                      ex_mem
);

        fwd_sel_e        fwd_a;
        fwd_sel_e        fwd_b;
        logic            ex_fwd_ok;
        logic            wb_fwd_ok;
        logic [XLEN-1:0] op_a;
        logic [XLEN-1:0] rs2_fwd;
        logic [XLEN-1:0] op_b;
        logic [XLEN-1:0] result;

        function automatic logic [XLEN-1:0] fwd_mux(
                input fwd_sel_e        sel,
                input logic [XLEN-1:0] reg_val,
                input logic [XLEN-1:0] ex_val,
                input logic [XLEN-1:0] wb_val
        );
                case (sel)
                        FWD_EX_MEM: return ex_val;
                        FWD_MEM_WB: return wb_val;
                        default:    return reg_val;
                endcase
        endfunction

        //////////////////////////////
        // Forwarding
        //////////////////////////////

        // Load in EX/MEM never matches here, stall covers it
        assign ex_fwd_ok = ex_mem.reg_write && !ex_mem.mem_read && (ex_mem.rd != '0);
        assign wb_fwd_ok = i_wb_write && (i_wb_rd != '0);

        // Newer EX/MEM result wins
        always_comb begin
                fwd_a = FWD_NONE;
                fwd_b = FWD_NONE;
                if (wb_fwd_ok && i_wb_rd == id_ex.rs1) fwd_a = FWD_MEM_WB;
                if (wb_fwd_ok && i_wb_rd == id_ex.rs2) fwd_b = FWD_MEM_WB;
                if (ex_fwd_ok && ex_mem.rd == id_ex.rs1) fwd_a = FWD_EX_MEM;
                if (ex_fwd_ok && ex_mem.rd == id_ex.rs2) fwd_b = FWD_EX_MEM;
        end

        assign op_a    = fwd_mux(fwd_a, id_ex.rs1_data, ex_mem.alu_result, i_wb_data);
        assign rs2_fwd = fwd_mux(fwd_b, id_ex.rs2_data, ex_mem.alu_result, i_wb_data);
        assign op_b    = id_ex.use_imm ? id_ex.imm : rs2_fwd;

        //////////////////////////////
        // ALU and EX/MEM
        //////////////////////////////

        always_comb begin
                case (id_ex.alu_op)
                        ALU_SUB: result = op_a - op_b;
                        ALU_AND: result = op_a & op_b;
                        ALU_OR:  result = op_a | op_b;
                        ALU_XOR: result = op_a ^ op_b;
                        // Signed compare
                        ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
                        default: result = op_a + op_b;
                endcase
        end

        always_ff @(posedge clk or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        ex_mem.reg_write <= 1'b0;
                        ex_mem.mem_read  <= 1'b0;
                        ex_mem.mem_write <= 1'b0;
                end else begin
                        ex_mem.reg_write <= id_ex.reg_write;
                        ex_mem.mem_read  <= id_ex.mem_read;
                        ex_mem.mem_write <= id_ex.mem_write;
                end
        end

        // Store data is the forwarded rs2
        always_ff @(posedge clk) begin
                ex_mem.alu_result <= result;
                ex_mem.store_data <= rs2_fwd;
                ex_mem.rd         <= id_ex.rd;
        end

endmodule

`default_nettype wire

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage import riscv_pkg::*; (
        input  wire logic                  clk,
        input  wire logic                  i_arst_n,
        input  wire logic [INSTR_W-1:0]    i_instr,
        input  wire logic                  i_wb_write,
        input  wire logic [REG_ADDR_W-1:0] i_wb_rd,
        input  wire logic [XLEN-1:0]       i_wb_data,
        output logic                       o_load_stall,
        id_ex_if.src                       id_ex
);

        opcode_e               opcode;
        logic [2:0]            funct3;
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       regs [2**REG_ADDR_W];

        // Control from the decoder
        alu_op_e               alu_op;
        logic                  use_imm;
        logic [XLEN-1:0]       imm;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;

        //////////////////////////////
        // Field split
        //////////////////////////////

        assign opcode = opcode_e'(i_instr[6:0]);
        assign rd     = i_instr[11:7];
        assign funct3 = i_instr[14:12];
        assign rs1    = i_instr[19:15];
        assign rs2    = i_instr[24:20];
        assign funct7 = i_instr[31:25];

        //////////////////////////////
        // Control
        //////////////////////////////

        always_comb begin
                alu_op    = ALU_ADD;
                use_imm   = 1'b0;
                imm       = '0;
                reg_write = 1'b0;
                mem_read  = 1'b0;
                mem_write = 1'b0;
                case (opcode)
                        OP_REG: begin
                                reg_write = 1'b1;
                                case (funct3)
                                        3'b000:  alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                                        3'b010:  alu_op = ALU_SLT;
                                        3'b100:  alu_op = ALU_XOR;
                                        3'b110:  alu_op = ALU_OR;
                                        3'b111:  alu_op = ALU_AND;
                                        default: alu_op = ALU_ADD;
                                endcase
                        end
                        // ADDI only
                        OP_IMM: begin
                                reg_write = 1'b1;
                                use_imm   = 1'b1;
                                imm       = {{(XLEN-12){i_instr[31]}}, i_instr[31:20]};
                        end
                        // Address = rs1 + I immediate
                        OP_LOAD: begin
                                reg_write = 1'b1;
                                mem_read  = 1'b1;
                                use_imm   = 1'b1;
                                imm       = {{(XLEN-12){i_instr[31]}}, i_instr[31:20]};
                        end
                        // Split S immediate
                        OP_STORE: begin
                                mem_write = 1'b1;
                                use_imm   = 1'b1;
                                imm       = {{(XLEN-12){i_instr[31]}}, i_instr[31:25],
                                             i_instr[11:7]};
                        end
                        // Unknown opcodes act as NOPs
                        default: ;
                endcase
        end

        //////////////////////////////
        // Register file
        //////////////////////////////

        // Writeback already excludes x0
        always_ff @(posedge clk) begin
                if (i_wb_write) begin
                        regs[i_wb_rd] <= i_wb_data;
                end
        end

        // x0 reads zero, same-cycle write passes through
        assign rs1_data = (rs1 == '0) ? '0 :
                          (i_wb_write && i_wb_rd == rs1) ? i_wb_data : regs[rs1];
        assign rs2_data = (rs2 == '0) ? '0 :
                          (i_wb_write && i_wb_rd == rs2) ? i_wb_data : regs[rs2];

        //////////////////////////////
        // Load-use and ID/EX
        //////////////////////////////

        // Load result not ready for the next instruction
        assign o_load_stall = id_ex.mem_read && (id_ex.rd != '0) &&
                              (id_ex.rd == rs1 || id_ex.rd == rs2);

        // Stall turns this slot into a bubble
        always_ff @(posedge clk or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        id_ex.reg_write <= 1'b0;
                        id_ex.mem_read  <= 1'b0;
                        id_ex.mem_write <= 1'b0;
                end else if (o_load_stall) begin
                        id_ex.reg_write <= 1'b0;
                        id_ex.mem_read  <= 1'b0;
                        id_ex.mem_write <= 1'b0;
                end else begin
                        id_ex.reg_write <= reg_write;
                        id_ex.mem_read  <= mem_read;
                        id_ex.mem_write <= mem_write;
                end
        end

        // Payload
        always_ff @(posedge clk) begin
                id_ex.alu_op   <= alu_op;
                id_ex.use_imm  <= use_imm;
                id_ex.imm      <= imm;
                id_ex.rs1      <= rs1;
                id_ex.rs2      <= rs2;
                id_ex.rs1_data <= rs1_data;
                id_ex.rs2_data <= rs2_data;
                id_ex.rd       <= rd;
        end

endmodule

`default_nettype wire

// ==== src/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import riscv_pkg::*; #(
        parameter int IMEM_AW = 6
) (
        input  wire logic               clk,
        input  wire logic               i_arst_n,
        input  wire logic               i_run,
        input  wire logic               i_load_stall,
        input  wire logic               i_imem_we,
        input  wire logic [IMEM_AW-1:0] i_imem_addr,
        input  wire logic [INSTR_W-1:0] i_imem_data,
        output logic      [INSTR_W-1:0] o_instr
);

        // addi x0, x0, 0
        localparam logic [INSTR_W-1:0] NOP = 32'h0000_0013;

        logic [INSTR_W-1:0] imem [2**IMEM_AW];
        // Byte address, low two bits stay zero
        logic [IMEM_AW+1:0] pc;
        logic [INSTR_W-1:0] fetched;

        //////////////////////////////
        // Instruction memory
        //////////////////////////////

        // Load port, only used before the run
        always_ff @(posedge clk) begin
                if (i_imem_we) begin
                        imem[i_imem_addr] <= i_imem_data;
                end
        end

        // Asynchronous read at the word index
        assign fetched = imem[pc[IMEM_AW+1:2]];

        //////////////////////////////
        // PC and IF/ID
        //////////////////////////////

        // Hold while idle or stalled
        always_ff @(posedge clk or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        pc <= '0;
                end else if (i_run && !i_load_stall) begin
                        pc <= pc + (IMEM_AW+2)'(4);
                end
        end

        // Idle pipeline sees only NOPs
        always_ff @(posedge clk or negedge i_arst_n) begin
                if (!i_arst_n) begin
                        o_instr <= NOP;
                end else if (!i_run) begin
                        o_instr <= NOP;
                end else if (!i_load_stall) begin
                        o_instr <= fetched;
                end
        end

endmodule

`default_nettype wire

// ==== src/riscv_pipe_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Decode to execute
interface id_ex_if import riscv_pkg::*; ();

        alu_op_e               alu_op;
        logic                  use_imm;
        logic [XLEN-1:0]       imm;
        // Source indices, kept for forwarding
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [REG_ADDR_W-1:0] rd;
        // Control bits, cleared on a bubble
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;

        // Decode side, also reads rd and mem_read back
        modport src (
                output alu_op, use_imm, imm, rs1, rs2, rs1_data, rs2_data,
                output rd, reg_write, mem_read, mem_write
        );

        modport dst (
                input alu_op, use_imm, imm, rs1, rs2, rs1_data, rs2_data,
                input rd, reg_write, mem_read, mem_write
        );

endinterface

// Execute to memory
interface ex_mem_if import riscv_pkg::*; ();

        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;

        // Execute side, reads its own outputs for forwarding
        modport src (
                output alu_result, store_data, rd, reg_write, mem_read, mem_write
        );

        modport dst (
                input alu_result, store_data, rd, reg_write, mem_read, mem_write
        );

endinterface

`default_nettype wire

// ==== src/riscv_pkg.sv ====
`default_nettype none

package riscv_pkg;

        //////////////////////////////
        // Widths
        //////////////////////////////

        // Data path and register file
        localparam int XLEN       = 32;
        localparam int REG_ADDR_W = 5;
        localparam int INSTR_W    = 32;

        //////////////////////////////
        // Encodings
        //////////////////////////////

        // Major opcodes of the supported subset
        typedef enum logic [6:0] {
                OP_REG   = 7'b0110011,
                OP_IMM   = 7'b0010011,
                OP_LOAD  = 7'b0000011,
                OP_STORE = 7'b0100011
        } opcode_e;

        // ALU operations
        typedef enum logic [2:0] {
                ALU_ADD,
                ALU_SUB,
                ALU_AND,
                ALU_OR,
                ALU_XOR,
                ALU_SLT
        } alu_op_e;

        // Operand source in execute
        typedef enum logic [1:0] {
                FWD_NONE,
                FWD_EX_MEM,
                FWD_MEM_WB
        } fwd_sel_e;

endpackage

`default_nettype wire
